//--- include/armShift_cfg.svh
`ifndef ARMSHIFT_CFG_SVH
`define ARMSHIFT_CFG_SVH

// Datapath word
`define ARM_WORD_W 32

// Shift amount from the instruction immediate field
`define ARM_SHAMT_W 5

// Shift amount from the bottom byte of Rs
`define ARM_RSAMT_W 8

// Rotator select vectors
`define SH_COARSE_W 8   // Steps of four
`define SH_FINE_W 5     // Steps of one plus the zero mark

`endif

//--- runSim.sh
#!/bin/sh
# Build and run the shifter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simShifterUnit

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module shifterUnitTb -f shifterUnit.f \
    --Mdir obj_dir -o "$BIN"; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi

echo "Simulation did not report a pass"
exit 1

//--- shifterUnit.f
+incdir+include
src/armShiftPkg.sv
src/shiftCtlPkg.sv
src/shiftControl.sv
src/shiftDecoder.sv
src/barrelRotator.sv
src/shiftMask.sv
src/shifterUnit.sv
verif/shifterUnitTb.sv

//--- src/armShiftPkg.sv
`default_nettype none

`include "armShift_cfg.svh"

package armShiftPkg;

  // Operand and result words
  typedef logic [`ARM_WORD_W-1:0] armWord;

  // Immediate amount, also the low part of any effective amount
  typedef logic [`ARM_SHAMT_W-1:0] shamtT;

  // Register-specified amount, only the low byte of Rs
  typedef logic [`ARM_RSAMT_W-1:0] rsAmtT;

  // Shift kind as encoded in instruction bits 6:5
  typedef logic [1:0] shTypeT;

  localparam shTypeT SH_LSL = 2'b00;
  localparam shTypeT SH_LSR = 2'b01;
  localparam shTypeT SH_ASR = 2'b10;
  localparam shTypeT SH_ROR = 2'b11;  // Also RRX when the immediate is 0

endpackage

`default_nettype wire

//--- src/barrelRotator.sv
`timescale 1ns/1ps
`default_nettype none

`include "armShift_cfg.svh"

module barrelRotator (
  input  armShiftPkg::armWord    a,
  input  shiftCtlPkg::coarseSelT coarseSel,
  input  shiftCtlPkg::fineSelT   fineSel,
  output armShiftPkg::armWord    rot
);

  import armShiftPkg::*;
  import shiftCtlPkg::*;

  armWord coarseRot;  // After the by-4 level
  armWord fineRot;    // After the by-1 level

  // Rotate right by a constant, n below the word width
  function automatic armWord rotr(input armWord x, input int unsigned n);
    rotr = (x >> n) | (x << (`ARM_WORD_W - n));
  endfunction

  // First level, one leg per multiple of four
  always_comb begin
    coarseRot = '0;
    for (int k = 0; k < `SH_COARSE_W; k++) begin
      coarseRot |= {`ARM_WORD_W{coarseSel[k]}} & rotr(a, 4 * k);
    end
  end

  // Second level, 0 to 3 more
  always_comb begin
    fineRot = '0;
    for (int j = 0; j < FINE_ZERO_BIT; j++) begin
      fineRot |= {`ARM_WORD_W{fineSel[j]}} & rotr(coarseRot, j);
    end
  end

  // Zero rotation skips both levels
  assign rot = fineSel[FINE_ZERO_BIT] ? a : fineRot;

endmodule

`default_nettype wire

//--- src/shiftControl.sv
`timescale 1ns/1ps
`default_nettype none

`include "armShift_cfg.svh"

module shiftControl (
  input  armShiftPkg::shTypeT shtype,
  input  armShiftPkg::shamtT  rShamt0,     // Immediate amount, raw
  input  armShiftPkg::rsAmtT  rsrShamt,    // Rs[7:0]
  input  logic                isRtype,
  input  logic                isRsrType,
  input  logic                zeroRotate,  // Immediate form with zero rotation
  input  logic                prevCflag,
  input  logic                multCsel,
  input  logic                multCarryIn,
  input  logic                a0,
  input  logic                a31,
  input  logic                rot0,
  input  logic                rot31,
  output armShiftPkg::shamtT  shamt,
  output logic                shift,
  output logic                left,
  output logic                arith,
  output logic                longshift,
  output logic                rrxIn,
  output logic                shifterCarryOut
);

  import armShiftPkg::*;

  logic                  rrx;
  logic                  shiftSelect;
  logic                  immLong;
  shamtT                 rAmt;
  logic [`ARM_SHAMT_W:0] effAmt;   // One extra bit for amount 32 and up
  logic                  shift0;
  logic                  shift32;
  logic                  shift33;

  // ROR #0 in the immediate form is RRX
  assign rrx = (shtype == SH_ROR) & isRtype & ~isRsrType & (rShamt0 == '0);
  assign rAmt = rrx ? shamtT'(1) : rShamt0;  // RRX moves one bit like ROR #1

  assign shiftSelect = isRtype | isRsrType;

  // Immediate 0 encodes 32 for LSR and ASR, LSL #0 stays 0
  assign immLong = (shtype != SH_LSL) & (rAmt == '0);

  always_comb begin
    if (!shiftSelect) begin
      effAmt = '0;  // Operand passes through
    end else if (isRsrType) begin
      effAmt = {(|rsrShamt[`ARM_RSAMT_W-1:`ARM_SHAMT_W]), rsrShamt[`ARM_SHAMT_W-1:0]};
    end else begin
      effAmt = {immLong, rAmt};
    end
  end

  assign longshift = effAmt[`ARM_SHAMT_W];  // Mask everything in the shift paths
  assign shamt     = effAmt[`ARM_SHAMT_W-1:0];

  always_comb begin
    unique case (shtype)
      SH_LSL:  {shift, left, arith} = 3'b110;
      SH_LSR:  {shift, left, arith} = 3'b100;
      SH_ASR:  {shift, left, arith} = 3'b101;
      default: {shift, left, arith} = 3'b000;  // ROR and RRX rotate only
    endcase
  end

  // Fill bit for RRX
  // Outside RRX it equals a0, which is what ROR #1 puts in bit 31 anyway
  always_comb begin
    if (!rrx) rrxIn = a0;
    else if (multCsel) rrxIn = multCarryIn;
    else rrxIn = prevCflag;
  end

  // Amount classes
  // The folded register amount aliases 64 onto 32, so the RSR cases use all of Rs
  assign shift0  = (effAmt == '0);
  assign shift32 = isRsrType ? (rsrShamt == rsAmtT'(`ARM_WORD_W))
                             : (effAmt == (`ARM_SHAMT_W+1)'(`ARM_WORD_W));
  assign shift33 = isRsrType & (rsrShamt > rsAmtT'(`ARM_WORD_W));  // Immediate never exceeds 32

  always_comb begin
    if (!shiftSelect) begin
      shifterCarryOut = zeroRotate ? prevCflag : a31;  // Immediate operand rule
    end else if (shift0) begin
      shifterCarryOut = prevCflag;
    end else if (shift33) begin
      unique case (shtype)
        SH_LSL:  shifterCarryOut = 1'b0;
        SH_LSR:  shifterCarryOut = 1'b0;
        SH_ASR:  shifterCarryOut = a31;   // Sign smeared
        default: shifterCarryOut = rot31; // ROR by amount mod 32
      endcase
    end else if (shift32) begin
      shifterCarryOut = (shtype == SH_LSL) ? a0 : a31;
    end else begin
      shifterCarryOut = left ? rot0 : rot31;  // Last bit out, RRX included
    end
  end

  // Immediate LSL is limited to 0..31, any long flag there is a decode bug
  always_comb begin
    assert final (!(longshift && isRtype && !isRsrType && shtype == SH_LSL))
      else $error("longshift raised for immediate LSL");
  end

  // Non-shift operands must reach the rotator unrotated
  always_comb begin
    assert final (shiftSelect || (shamt == '0 && !longshift))
      else $error("nonzero amount without a shift form");
  end

endmodule

`default_nettype wire

//--- src/shiftCtlPkg.sv
`default_nettype none

`include "armShift_cfg.svh"

package shiftCtlPkg;

  // One-hot, bit k rotates right by 4k
  typedef logic [`SH_COARSE_W-1:0] coarseSelT;

  // Bits 0..3 one-hot rotate right by 0..3
  // Top bit flags a zero rotation so the rotator passes its input straight out
  typedef logic [`SH_FINE_W-1:0] fineSelT;

  // Position of the zero-rotation mark
  localparam int unsigned FINE_ZERO_BIT = `SH_FINE_W - 1;

endpackage

`default_nettype wire

//--- src/shiftDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module shiftDecoder (
  input  armShiftPkg::shamtT     shamt,
  input  logic                   left,
  output shiftCtlPkg::coarseSelT coarseSel,
  output shiftCtlPkg::fineSelT   fineSel
);

  import armShiftPkg::*;
  import shiftCtlPkg::*;

  shamtT rotAmt;

  // Left by n is right by (32 - n) mod 32 which is the two's complement in 5 bits
  assign rotAmt = left ? shamtT'(~shamt + 1'b1) : shamt;

  always_comb begin
    coarseSel = '0;
    fineSel   = '0;
    coarseSel[rotAmt[4:2]] = 1'b1;  // Multiples of four
    if (rotAmt == '0) begin
      fineSel[FINE_ZERO_BIT] = 1'b1;  // Bypass marker alone
    end else begin
      fineSel[rotAmt[1:0]] = 1'b1;
    end
  end

  // AND-OR rotator relies on exactly one coarse leg
  always_comb begin
    assert final ($onehot(coarseSel))
      else $error("coarseSel not one-hot");
  end

endmodule

`default_nettype wire

//--- src/shiftMask.sv
`timescale 1ns/1ps
`default_nettype none

`include "armShift_cfg.svh"

module shiftMask (
  input  armShiftPkg::armWord rot,
  input  logic                a31,
  input  armShiftPkg::shamtT  shamt,
  input  logic                shift,
  input  logic                left,
  input  logic                arith,
  input  logic                longshift,
  input  logic                rrxIn,
  output armShiftPkg::armWord y
);

  import armShiftPkg::*;

  localparam armWord ALL_ONES = '1;

  armWord keepMask;  // Bits that come from the rotated word
  armWord fill;      // Value for the vacated bits
  armWord shiftY;
  logic   rorTop;    // Bit 31 in the rotate path

  // Left keeps the upper 32-n bits, right keeps the lower 32-n bits
  always_comb begin
    if (longshift) begin
      keepMask = '0;  // 32 and up, nothing survives
    end else if (left) begin
      keepMask = ALL_ONES << shamt;
    end else begin
      keepMask = ALL_ONES >> shamt;
    end
  end

  assign fill = arith ? {`ARM_WORD_W{a31}} : '0;  // Sign fill for ASR only

  assign shiftY = (rot & keepMask) | (fill & ~keepMask);

  // Only a one-bit rotation can be RRX
  // For a plain ROR #1 rrxIn is a0, the same bit the rotator put there
  assign rorTop = (shamt == shamtT'(1)) ? rrxIn : rot[`ARM_WORD_W-1];

  assign y = shift ? shiftY : {rorTop, rot[`ARM_WORD_W-2:0]};

endmodule

`default_nettype wire

//--- src/shifterUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "armShift_cfg.svh"

module shifterUnit (
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  input  logic                setFlags,     // Update cFlag with this op's carry
  input  armShiftPkg::armWord a,
  input  armShiftPkg::shTypeT shtype,
  input  armShiftPkg::shamtT  rShamt0,
  input  armShiftPkg::rsAmtT  rsrShamt,
  input  logic                isRtype,
  input  logic                isRsrType,
  input  logic                zeroRotate,
  input  logic                multCsel,     // RRX fill from the multiplier
  input  logic                multCarryIn,
  output logic                outValid,
  output armShiftPkg::armWord result,
  output logic                carryOut,
  output logic                cFlag
);

  import armShiftPkg::*;
  import shiftCtlPkg::*;

  shamtT     shamt;
  logic      shift;
  logic      left;
  logic      arith;
  logic      longshift;
  logic      rrxIn;
  logic      shifterCarryOut;
  coarseSelT coarseSel;
  fineSelT   fineSel;
  armWord    rot;
  armWord    y;

  shiftControl i_shiftControl (
    .shtype          (shtype),
    .rShamt0         (rShamt0),
    .rsrShamt        (rsrShamt),
    .isRtype         (isRtype),
    .isRsrType       (isRsrType),
    .zeroRotate      (zeroRotate),
    .prevCflag       (cFlag),
    .multCsel        (multCsel),
    .multCarryIn     (multCarryIn),
    .a0              (a[0]),
    .a31             (a[`ARM_WORD_W-1]),
    .rot0            (rot[0]),             // Last bit out for LSL
    .rot31           (rot[`ARM_WORD_W-1]), // Last bit out for right shifts
    .shamt           (shamt),
    .shift           (shift),
    .left            (left),
    .arith           (arith),
    .longshift       (longshift),
    .rrxIn           (rrxIn),
    .shifterCarryOut (shifterCarryOut)
  );

  shiftDecoder i_shiftDecoder (
    .shamt     (shamt),
    .left      (left),
    .coarseSel (coarseSel),
    .fineSel   (fineSel)
  );

  barrelRotator i_barrelRotator (
    .a         (a),
    .coarseSel (coarseSel),
    .fineSel   (fineSel),
    .rot       (rot)
  );

  shiftMask i_shiftMask (
    .rot       (rot),
    .a31       (a[`ARM_WORD_W-1]),
    .shamt     (shamt),
    .shift     (shift),
    .left      (left),
    .arith     (arith),
    .longshift (longshift),
    .rrxIn     (rrxIn),
    .y         (y)
  );

  // Single output stage taking one op per cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
      result   <= '0;
      carryOut <= 1'b0;
      cFlag    <= 1'b0;
    end else begin
      outValid <= inValid;  // Strobe only
      if (inValid) begin
        result   <= y;
        carryOut <= shifterCarryOut;
      end
      if (inValid && setFlags) cFlag <= shifterCarryOut;  // Seen by the next op
    end
  end

  // Without a shift form the operand reaches the result untouched
  assert property (@(posedge clk) disable iff (!arstN)
                   inValid && !isRtype && !isRsrType |=> result == $past(a))
    else $error("operand changed without a shift form");

endmodule

`default_nettype wire

//--- verif/shifterUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module shifterUnitTb;

  import armShiftPkg::*;

  localparam int TIMEOUT_CYC = 20;  // Longest wait for any output
  localparam int N_RAND      = 200;

  logic   clk = 1'b0;
  logic   arstN, inValid, setFlags, isRtype, isRsrType, zeroRotate, multCsel, multCarryIn;
  armWord a;
  shTypeT shtype;
  shamtT  rShamt0;
  rsAmtT  rsrShamt;
  logic   outValid, carryOut, cFlag;
  armWord result;

  logic [31:0] rngState;
  logic        modelCflag;  // Model copy of the carry flag
  logic        validSent;   // inValid as seen by the last rising edge
  logic        checkOn;
  int          checks, errors, testChecks, testErrors;
  armWord      expRes[$];
  logic        expCarry[$];
  logic        expFlag[$];
  string       expName[$];

  always #5 clk = ~clk;

  always @(posedge clk) validSent <= inValid;

  shifterUnit i_shifterUnit (
    .clk (clk), .arstN (arstN), .inValid (inValid), .setFlags (setFlags), .a (a),
    .shtype (shtype), .rShamt0 (rShamt0), .rsrShamt (rsrShamt), .isRtype (isRtype),
    .isRsrType (isRsrType), .zeroRotate (zeroRotate), .multCsel (multCsel),
    .multCarryIn (multCarryIn), .outValid (outValid), .result (result),
    .carryOut (carryOut), .cFlag (cFlag)
  );

  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // ARM shift by a decoded amount returning {carry, word}
  function automatic logic [32:0] shiftRef(input armWord x, input shTypeT kind, input int amt,
                                           input logic cin);
    armWord r;
    logic   c;
    int     rr;
    r  = x;    // Amount 0 keeps operand and carry
    c  = cin;
    rr = amt % 32;
    if (amt != 0) begin
      for (int i = 0; i < 32; i++) begin
        case (kind)
          SH_LSL:  r[i] = (i >= amt) ? x[i - amt] : 1'b0;
          SH_LSR:  r[i] = (i + amt < 32) ? x[i + amt] : 1'b0;
          SH_ASR:  r[i] = (i + amt < 32) ? x[i + amt] : x[31];
          default: r[i] = x[(i + rr) % 32];
        endcase
      end
      case (kind)
        SH_LSL:  c = (amt <= 32) ? x[32 - amt] : 1'b0;
        SH_LSR:  c = (amt <= 32) ? x[amt - 1] : 1'b0;
        SH_ASR:  c = (amt <= 32) ? x[amt - 1] : x[31];
        default: c = (rr == 0) ? x[31] : x[rr - 1];  // Multiples of 32 give bit 31
      endcase
    end
    return {c, r};
  endfunction

  function automatic logic [32:0] opRef(input armWord x, input shTypeT kind, input shamtT imm,
                                        input rsAmtT rs, input logic rForm, input logic rsrForm,
                                        input logic zr, input logic fill, input logic cin);
    int amt;
    amt = imm;
    if (rsrForm) return shiftRef(x, kind, rs, cin);
    if (!rForm) return {zr ? cin : x[31], x};  // Operand passes through
    if (kind == SH_ROR && imm == 0) return {x[0], fill, x[31:1]};  // RRX
    if (kind != SH_LSL && imm == 0) amt = 32;
    return shiftRef(x, kind, amt, cin);
  endfunction

  // Drives one op on the next falling edge and queues its expected values
  task automatic issue(input string name, input armWord x, input shTypeT kind, input shamtT imm,
                       input rsAmtT rs, input logic rForm, input logic rsrForm, input logic zr,
                       input logic sf);
    logic [32:0] exp;
    logic [31:0] rb;
    rb = nextRand();
    @(negedge clk);
    a           = x;
    shtype      = kind;
    rShamt0     = imm;
    rsrShamt    = rs;
    isRtype     = rForm;
    isRsrType   = rsrForm;
    zeroRotate  = zr;
    setFlags    = sf;
    multCsel    = rb[31];
    multCarryIn = rb[30];
    inValid     = 1'b1;
    exp = opRef(x, kind, imm, rs, rForm, rsrForm, zr, rb[31] ? rb[30] : modelCflag, modelCflag);
    if (sf) modelCflag = exp[32];
    expRes.push_back(exp[31:0]);
    expCarry.push_back(exp[32]);
    expFlag.push_back(modelCflag);
    expName.push_back(name);
  endtask

  task automatic idle();
    @(negedge clk);
    inValid  = 1'b0;
    setFlags = 1'b0;
  endtask

  task automatic drain();
    int n;
    idle();
    n = 0;
    while (expRes.size() != 0 && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (expRes.size() != 0) begin
      errors++;
      $display("Timeout: %0d results never came out", expRes.size());
      expRes.delete();
      expCarry.delete();
      expFlag.delete();
      expName.delete();
    end
  endtask

  task automatic startTest();
    testChecks = checks;
    testErrors = errors;
  endtask

  task automatic endTest(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - testChecks, errors - testErrors);
  endtask

  // Registered outputs are stable at the falling edge
  always @(negedge clk) begin
    if (checkOn) begin
      compare("outValid", validSent, outValid);
      if (outValid && expRes.size() == 0) begin
        errors++;
        $display("Result came out with no operation pending");
      end else if (outValid) begin
        compare({expName[0], ".result"}, expRes.pop_front(), result);
        compare({expName[0], ".carry"}, expCarry.pop_front(), carryOut);
        compare({expName[0], ".cFlag"}, expFlag.pop_front(), cFlag);
        void'(expName.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] r;
    int          n;
    rngState = 32'he833;
    arstN = 1'b0;
    {inValid, setFlags, isRtype, isRsrType, zeroRotate, multCsel, multCarryIn} = '0;
    a          = '0;
    shtype     = SH_LSL;
    rShamt0    = '0;
    rsrShamt   = '0;
    modelCflag = 1'b0;
    checkOn    = 1'b0;
    checks     = 0;
    errors     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;

    startTest();
    compare("reset.outValid", 1'b0, outValid);
    compare("reset.cFlag", 1'b0, cFlag);
    compare("reset.result", 32'h0, result);
    checkOn = 1'b1;
    issue("latency", nextRand(), SH_LSR, 5'd3, '0, 1'b1, 1'b0, 1'b0, 1'b0);
    n = 0;
    do begin
      idle();
      n++;
    end while (!outValid && n < TIMEOUT_CYC);
    if (!outValid) $display("Timeout: outValid never rose after a single op");
    compare("latency.cycles", 1, n);
    for (int i = 0; i < 8; i++) begin
      issue("backToBack", nextRand(), shTypeT'(i), shamtT'(i + 1), '0, 1'b1, 1'b0, 1'b0, 1'b1);
    end
    drain();
    endTest("reset and strobe timing");

    startTest();
    for (int i = 0; i < N_RAND; i++) begin
      r = nextRand();
      issue("immShift", nextRand(), shTypeT'(r[31:30]), (r[29:25] == 0) ? 5'd1 : r[29:25],
            '0, 1'b1, 1'b0, r[23], r[24]);
    end
    drain();
    endTest("immediate shifts");

    startTest();
    for (int i = 0; i < 60; i++) begin
      r = nextRand();
      issue("immZero", nextRand(), shTypeT'(r[31:30]), '0, '0, 1'b1, 1'b0, 1'b0, r[29]);
    end
    drain();
    endTest("immediate amount zero");

    startTest();
    for (int i = 0; i < N_RAND; i++) begin
      r = nextRand();
      case (r[31:30])
        2'd0:    n = 0;
        2'd1:    n = 32;
        2'd2:    n = 33 + (r[29:22] % 223);  // 33 to 255
        default: n = r[21:14];
      endcase
      issue("regShift", nextRand(), shTypeT'(r[13:12]), '0, rsAmtT'(n), 1'b0, 1'b1, 1'b0, r[11]);
    end
    drain();
    endTest("register shifts");

    startTest();
    for (int i = 0; i < 60; i++) begin
      r = nextRand();
      issue("noShift", nextRand(), shTypeT'(r[31:30]), r[29:25], r[24:17], 1'b0, 1'b0,
            r[16], r[15]);
    end
    drain();
    endTest("pass through");

    startTest();
    issue("flagSet", 32'h1, SH_LSR, 5'd1, '0, 1'b1, 1'b0, 1'b0, 1'b1);      // Carry 1 stored
    issue("flagRead", nextRand(), SH_LSL, '0, '0, 1'b0, 1'b0, 1'b1, 1'b0);  // Returns cFlag
    issue("flagHold", 32'h0, SH_LSR, 5'd1, '0, 1'b1, 1'b0, 1'b0, 1'b0);     // Carry 0 not stored
    issue("flagRead", nextRand(), SH_LSL, '0, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    issue("flagClear", 32'h0, SH_LSR, 5'd1, '0, 1'b1, 1'b0, 1'b0, 1'b1);
    issue("flagRead", nextRand(), SH_LSL, '0, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < 60; i++) begin
      r = nextRand();
      issue("flagMix", nextRand(), shTypeT'(r[31:30]), r[29:25], r[24:17], r[16], ~r[16],
            r[15], r[14]);
    end
    drain();
    endTest("carry flag");

    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
